//--- cpu_golden.mem
// columns, all hex: M address word | W store address data | O output value
// H instruction bound for the watchdog; W and O entries are checked in order
H 0050
// arithmetic, logic and immediates
M 0000 4105
M 0001 42FD
M 0002 F6C0
M 0003 FC1C
M 0004 F6C1
M 0005 FC1C
M 0006 6312
M 0007 5F34
M 0008 FC1C
M 0009 FD02
M 000A F01C
M 000B F203
M 000C F004
M 000D F005
M 000E F01C
M 000F FC06
M 0010 F01C
M 0011 F807
M 0012 F01C
// loads and stores around base 0080
M 0013 6000
M 0014 5080
M 0015 8300
M 0016 8201
M 0017 7110
M 0018 F41C
M 0019 7301
M 001A FC1C
M 001B 71FF
M 001C F41C
// branches, taken ones skip a stray WWD
M 001D 0B01
M 001E 4501
M 001F F41C
M 0020 1B01
M 0021 F41C
M 0022 4501
M 0023 F41C
M 0024 0201
M 0025 F41C
M 0026 1201
M 0027 4501
M 0028 F41C
M 0029 2001
M 002A F41C
M 002B 4501
M 002C F41C
M 002D 2801
M 002E 4501
M 002F F41C
M 0030 3801
M 0031 F41C
M 0032 4501
M 0033 F41C
M 0034 3001
M 0035 4501
M 0036 F41C
// jumps and subroutine calls
M 0037 903A
M 0038 F41C
M 0039 F01D
M 003A A040
M 003B F41C
M 003C 6300
M 003D 5F48
M 003E FC1A
M 003F F01D
M 0040 F81C
M 0041 4501
M 0042 F819
M 0048 F81C
M 0049 F819
// data words
M 007F 0777
M 0090 BEEF
W 0080 1234
W 0081 FFFD
O 0002
O 0008
O 1234
O 0004
O FFFE
O 2468
O 7FFE
O BEEF
O FFFD
O 0777
O 0778
O 0779
O 077A
O 077B
O 077C
O 077D
O 077E
O 003B
O 077F
O 003F

//--- all.f
cpu_pkg.sv
alu.sv
control_unit.sv
register_file.sv
bus_sequencer.sv
cpu.sv
tb_clock.sv
tb_memory.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu16

sources:
  - cpu_pkg.sv
  - alu.sv
  - control_unit.sv
  - register_file.sv
  - bus_sequencer.sv
  - cpu.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_memory.sv
      - tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	logic                 clk;
	logic                 rst_n;
	logic                 inputReady;
	logic                 ackOutput;
	logic                 readM;
	logic                 writeM;
	logic [word_size-1:0] address;
	wire  [word_size-1:0] data;
	logic [word_size-1:0] output_port;
	logic                 output_strobe;
	logic                 halted;

	// expectations are consumed in program order
	logic [word_size-1:0] exp_store_addr [$];
	logic [word_size-1:0] exp_store_data [$];
	logic [word_size-1:0] exp_out [$];
	int                   h_bound = 100;
	int                   value_errors = 0;
	int                   other_errors = 0;
	bit                   loaded = 1'b0;
	bit                   seen_halt = 1'b0;
	bit                   seen_request = 1'b0;
	logic                 prev_req = 1'b0;
	logic [word_size-1:0] prev_addr = '0;

	tb_clock clock_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	tb_memory memory_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.readM      (readM),
		.writeM     (writeM),
		.address    (address),
		.data       (data),
		.inputReady (inputReady),
		.ackOutput  (ackOutput)
	);

	cpu cpu_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.inputReady    (inputReady),
		.ackOutput     (ackOutput),
		.readM         (readM),
		.writeM        (writeM),
		.address       (address),
		.data          (data),
		.output_port   (output_port),
		.output_strobe (output_strobe),
		.halted        (halted)
	);

	task automatic load_program_file();
		int                   fd;
		int                   n;
		string                line;
		byte                  tag;
		logic [word_size-1:0] v1;
		logic [word_size-1:0] v2;
		memory_i.fill_pattern();
		fd = $fopen("cpu_golden.mem", "r");
		if (fd == 0) begin
			$display("could not open cpu_golden.mem for reading");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.getc(0) != "/") begin
				tag = line.getc(0);
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h", v1, v2);
				case (tag)
					"M": memory_i.write_word(v1, v2);
					"W": begin
						exp_store_addr.push_back(v1);
						exp_store_data.push_back(v2);
					end
					"O": exp_out.push_back(v1);
					"H": h_bound = v1;
					default: begin
						$display("unreadable line in cpu_golden.mem: %s", line);
						other_errors++;
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic watch_bus_cycle();
		logic                 req;
		logic [word_size-1:0] exp_a;
		logic [word_size-1:0] exp_d;
		req = readM || writeM;
		if (!rst_n) begin
			if (readM || writeM || output_strobe || halted) begin
				$display("FAILED at %0t: bus or status output active during reset", $time);
				value_errors++;
			end
		end else begin
			if (readM && writeM) begin
				$display("FAILED at %0t: readM and writeM high together", $time);
				value_errors++;
			end
			if (req && prev_req && address !== prev_addr) begin
				$display("FAILED at %0t: address moved from %h to %h under a pending request",
					$time, prev_addr, address);
				value_errors++;
			end
			// first request after reset is the fetch at address 0
			if (req && !seen_request) begin
				seen_request = 1'b1;
				if (!readM || address !== '0) begin
					$display("FAILED at %0t: first request is not a read of 0 (address %h)",
						$time, address);
					value_errors++;
				end
			end
			if (writeM && ackOutput) begin
				if (exp_store_addr.size() == 0) begin
					$display("store to %h at %0t was not expected", address, $time);
					other_errors++;
				end else begin
					exp_a = exp_store_addr.pop_front();
					exp_d = exp_store_data.pop_front();
					if (address !== exp_a || data !== exp_d) begin
						$display("FAILED at %0t: store %h to %h, expected %h to %h",
							$time, data, address, exp_d, exp_a);
						value_errors++;
					end
				end
			end
			if (output_strobe) begin
				if (exp_out.size() == 0) begin
					$display("output %h at %0t was not expected", output_port, $time);
					other_errors++;
				end else begin
					exp_d = exp_out.pop_front();
					if (output_port !== exp_d) begin
						$display("FAILED at %0t: output %h, expected %h",
							$time, output_port, exp_d);
						value_errors++;
					end
				end
			end
			if (seen_halt && !halted) begin
				$display("FAILED at %0t: halted dropped after rising", $time);
				value_errors++;
			end
			if (seen_halt && req) begin
				$display("FAILED at %0t: bus request after halt", $time);
				value_errors++;
			end
			if (halted)
				seen_halt = 1'b1;
		end
		prev_req  = req;
		prev_addr = address;
	endtask

	task automatic report_totals();
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
	endtask

	// sample just after the falling edge when nothing moves
	always @(negedge clk) begin
		#1;
		watch_bus_cycle();
	end

	initial begin
		void'($urandom(32'hd96e5538));
		memory_i.draw_latencies();
		load_program_file();
		loaded = 1'b1;
		wait (seen_halt);
		// keep watching the bus for a while after halt
		repeat (20) @(negedge clk);
		if (exp_store_addr.size() != 0) begin
			$display("%0d expected stores never happened", exp_store_addr.size());
			other_errors++;
		end
		if (exp_out.size() != 0) begin
			$display("%0d expected outputs never appeared", exp_out.size());
			other_errors++;
		end
		report_totals();
		if (value_errors == 0 && other_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog allows 12 cycles per instruction slot
	initial begin
		wait (loaded);
		#(h_bound * 12 * 10);
		$display("timeout: the processor did not halt within %0d instruction slots", h_bound);
		other_errors++;
		report_totals();
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          readM,
	input  logic                          writeM,
	input  logic [cpu_pkg::word_size-1:0] address,
	inout  wire  [cpu_pkg::word_size-1:0] data,
	output logic                          inputReady,
	output logic                          ackOutput
);
	import cpu_pkg::*;

	localparam int latency_count = 256;

	logic [word_size-1:0] mem [1 << word_size];
	logic [word_size-1:0] read_word;
	logic                 drive;
	logic                 busy;
	int                   wait_left;
	int                   latency;
	int                   latencies [latency_count];
	int                   next_latency;

	// data is only driven in the inputReady cycle
	assign data = drive ? read_word : 'z;

	task automatic fill_pattern();
		for (int i = 0; i < (1 << word_size); i++)
			mem[i] = word_size'(i) ^ 16'hc3a5;
	endtask

	task automatic write_word(input logic [word_size-1:0] a, input logic [word_size-1:0] w);
		mem[a] = w;
	endtask

	// 1 to 4 cycles per request, used in turn
	task automatic draw_latencies();
		for (int i = 0; i < latency_count; i++)
			latencies[i] = 1 + ($urandom % 4);
	endtask

	task automatic answer();
		if (writeM) begin
			mem[address] = data;
			ackOutput <= 1'b1;
		end else begin
			read_word  <= mem[address];
			drive      <= 1'b1;
			inputReady <= 1'b1;
		end
	endtask

	initial begin
		inputReady   = 1'b0;
		ackOutput    = 1'b0;
		drive        = 1'b0;
		busy         = 1'b0;
		wait_left    = 0;
		read_word    = '0;
		next_latency = 0;
	end

	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inputReady <= 1'b0;
			ackOutput  <= 1'b0;
			drive      <= 1'b0;
			busy       <= 1'b0;
			wait_left  <= 0;
		end else if (inputReady || ackOutput) begin
			// one-cycle answer is over
			inputReady <= 1'b0;
			ackOutput  <= 1'b0;
			drive      <= 1'b0;
		end else if (busy) begin
			if (wait_left == 1) begin
				answer();
				busy <= 1'b0;
			end
			wait_left <= wait_left - 1;
		end else if (readM || writeM) begin
			// latency counted from the request edge
			latency      = latencies[next_latency % latency_count];
			next_latency = next_latency + 1;
			if (latency == 1) begin
				answer();
			end else begin
				busy      <= 1'b1;
				wait_left <= latency - 1;
			end
		end
	end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over four rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          inputReady,
	input  logic                          ackOutput,
	output logic                          readM,
	output logic                          writeM,
	output logic [cpu_pkg::word_size-1:0] address,
	inout  wire  [cpu_pkg::word_size-1:0] data,
	output logic [cpu_pkg::word_size-1:0] output_port,
	output logic                          output_strobe,
	output logic                          halted
);
	import cpu_pkg::*;

	logic [word_size-1:0]     pc;
	logic [word_size-1:0]     pc_plus_one;
	logic [word_size-1:0]     pc_plus_offset;
	logic [word_size-1:0]     pc_next;
	logic [word_size-1:0]     instruction;
	logic [word_size-1:0]     load_data;
	logic                     commit;
	logic [reg_addr_size-1:0] rs;
	logic [reg_addr_size-1:0] rt;
	logic [reg_addr_size-1:0] rd_sel;
	logic [word_size-1:0]     imm_ext;
	alu_op_t                  alu_op;
	pc_src_t                  pc_src;
	logic                     alu_src_imm;
	logic                     reg_write;
	logic                     mem_read;
	logic                     mem_write;
	logic                     mem_to_reg;
	logic                     pc_to_reg;
	logic                     is_wwd;
	logic                     is_halt;
	logic [word_size-1:0]     rs_data;
	logic [word_size-1:0]     rt_data;
	logic [word_size-1:0]     alu_b;
	logic [word_size-1:0]     alu_result;
	logic                     bcond;
	logic [word_size-1:0]     wr_data;

	// branch offsets are relative to the following instruction
	assign pc_plus_one    = pc + 1'b1;
	assign pc_plus_offset = pc_plus_one + imm_ext;

	assign alu_b = alu_src_imm ? imm_ext : rt_data;

	// jal and jrl link to the next instruction
	assign wr_data = pc_to_reg  ? pc_plus_one :
	                 mem_to_reg ? load_data   : alu_result;

	always_comb begin
		case (pc_src)
			pc_src_offset: pc_next = pc_plus_offset;
			pc_src_jump:   pc_next = imm_ext;
			pc_src_reg:    pc_next = alu_result;
			default:       pc_next = pc_plus_one;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc            <= '0;
			output_strobe <= 1'b0;
		end else begin
			if (commit)
				pc <= pc_next;
			output_strobe <= commit && is_wwd;
		end
	end

	always_ff @(posedge clk) begin
		if (commit && is_wwd)
			output_port <= alu_result;
	end

	bus_sequencer bus_sequencer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.pc          (pc),
		.mem_addr    (alu_result),
		.store_data  (rt_data),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.is_halt     (is_halt),
		.inputReady  (inputReady),
		.ackOutput   (ackOutput),
		.data        (data),
		.readM       (readM),
		.writeM      (writeM),
		.address     (address),
		.instruction (instruction),
		.load_data   (load_data),
		.commit      (commit),
		.halted      (halted)
	);

	control_unit control_unit_i (
		.instruction (instruction),
		.bcond       (bcond),
		.rs          (rs),
		.rt          (rt),
		.rd_sel      (rd_sel),
		.imm_ext     (imm_ext),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.reg_write   (reg_write),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_to_reg  (mem_to_reg),
		.pc_to_reg   (pc_to_reg),
		.is_wwd      (is_wwd),
		.is_halt     (is_halt),
		.pc_src      (pc_src)
	);

	register_file register_file_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs      (rs),
		.rt      (rt),
		.wr_addr (rd_sel),
		.wr_data (wr_data),
		.wr_en   (reg_write && commit),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	alu alu_i (
		.a      (rs_data),
		.b      (alu_b),
		.op     (alu_op),
		.opcode (instruction[15:12]),
		.result (alu_result),
		.bcond  (bcond)
	);

endmodule

//--- bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cpu_pkg::word_size-1:0] pc,
	input  logic [cpu_pkg::word_size-1:0] mem_addr,
	input  logic [cpu_pkg::word_size-1:0] store_data,
	input  logic                          mem_read,
	input  logic                          mem_write,
	input  logic                          is_halt,
	input  logic                          inputReady,
	input  logic                          ackOutput,
	inout  wire  [cpu_pkg::word_size-1:0] data,
	output logic                          readM,
	output logic                          writeM,
	output logic [cpu_pkg::word_size-1:0] address,
	output logic [cpu_pkg::word_size-1:0] instruction,
	output logic [cpu_pkg::word_size-1:0] load_data,
	output logic                          commit,
	output logic                          halted
);

	typedef enum logic [2:0] {
		s_fetch,
		s_execute,
		s_load,
		s_store,
		s_commit,
		s_halt
	} state_t;

	state_t state;

	// pc only matters while fetching, otherwise the ALU result addresses memory
	assign address = (state == s_fetch) ? pc : mem_addr;
	assign data    = writeM ? store_data : 'z;
	assign commit  = (state == s_commit);
	assign halted  = (state == s_halt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= s_fetch;
			readM  <= 1'b0;
			writeM <= 1'b0;
		end else begin
			case (state)
				s_fetch: begin
					// first cycle out of reset raises the request here
					if (readM && inputReady) begin
						readM <= 1'b0;
						state <= s_execute;
					end else begin
						readM <= 1'b1;
					end
				end
				s_execute: begin
					if (mem_read) begin
						readM <= 1'b1;
						state <= s_load;
					end else if (mem_write) begin
						writeM <= 1'b1;
						state  <= s_store;
					end else begin
						state <= s_commit;
					end
				end
				s_load: begin
					if (inputReady) begin
						readM <= 1'b0;
						state <= s_commit;
					end
				end
				s_store: begin
					if (ackOutput) begin
						writeM <= 1'b0;
						state  <= s_commit;
					end
				end
				s_commit: begin
					if (is_halt) begin
						state <= s_halt;
					end else begin
						readM <= 1'b1;
						state <= s_fetch;
					end
				end
				s_halt: ;
				default: state <= s_fetch;
			endcase
		end
	end

	// the memory drives data only in the inputReady cycle
	always_ff @(posedge clk) begin
		if (state == s_fetch && readM && inputReady)
			instruction <= data;
		if (state == s_load && inputReady)
			load_data <= data;
	end

	a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
		!(readM && writeM))
		else $error("read and write requested together");

	// address must hold until the memory has answered
	a_address_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(readM && !inputReady) || (writeM && !ackOutput) |=> $stable(address))
		else $error("address changed under a pending request");

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [cpu_pkg::reg_addr_size-1:0] rs,
	input  logic [cpu_pkg::reg_addr_size-1:0] rt,
	input  logic [cpu_pkg::reg_addr_size-1:0] wr_addr,
	input  logic [cpu_pkg::word_size-1:0]     wr_data,
	input  logic                              wr_en,
	output logic [cpu_pkg::word_size-1:0]     rs_data,
	output logic [cpu_pkg::word_size-1:0]     rt_data
);
	import cpu_pkg::*;

	logic [word_size-1:0] regs [reg_count];

	// asynchronous read ports
	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// a committing write must carry a fully resolved target and value
	a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown({wr_addr, wr_data}))
		else $error("register write with unknown address or data");

endmodule

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic [cpu_pkg::word_size-1:0]     instruction,
	input  logic                              bcond,
	output logic [cpu_pkg::reg_addr_size-1:0] rs,
	output logic [cpu_pkg::reg_addr_size-1:0] rt,
	output logic [cpu_pkg::reg_addr_size-1:0] rd_sel,
	output logic [cpu_pkg::word_size-1:0]     imm_ext,
	output cpu_pkg::alu_op_t                  alu_op,
	output logic                              alu_src_imm,
	output logic                              reg_write,
	output logic                              mem_read,
	output logic                              mem_write,
	output logic                              mem_to_reg,
	output logic                              pc_to_reg,
	output logic                              is_wwd,
	output logic                              is_halt,
	output cpu_pkg::pc_src_t                  pc_src
);
	import cpu_pkg::*;

	logic [3:0]               opcode;
	logic [5:0]               func;
	logic [reg_addr_size-1:0] rd;
	logic [7:0]               imm8;
	logic [11:0]              target;

	assign opcode = instruction[15:12];
	assign rs     = instruction[11:10];
	assign rt     = instruction[9:8];
	assign rd     = instruction[7:6];
	assign func   = instruction[5:0];
	assign imm8   = instruction[7:0];
	assign target = instruction[11:0];

	always_comb begin
		// I-type defaults, anything unknown falls through as a no-op
		rd_sel      = rt;
		imm_ext     = {{(word_size-8){imm8[7]}}, imm8};
		alu_op      = alu_add;
		alu_src_imm = 1'b0;
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_to_reg  = 1'b0;
		pc_to_reg   = 1'b0;
		is_wwd      = 1'b0;
		is_halt     = 1'b0;
		pc_src      = pc_src_next;
		case (opcode)
			op_bne, op_beq, op_bgz, op_blz: begin
				alu_op = alu_sub;
				if (bcond)
					pc_src = pc_src_offset;
			end
			op_adi: begin
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			op_ori: begin
				imm_ext     = {{(word_size-8){1'b0}}, imm8};
				alu_op      = alu_orr;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			op_lhi: begin
				imm_ext     = {imm8, 8'h00};
				alu_op      = alu_pass_b;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
			end
			op_lwd: begin
				alu_src_imm = 1'b1;
				mem_read    = 1'b1;
				mem_to_reg  = 1'b1;
				reg_write   = 1'b1;
			end
			op_swd: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
			end
			op_jmp: begin
				imm_ext = {4'b0000, target};
				pc_src  = pc_src_jump;
			end
			op_jal: begin
				imm_ext   = {4'b0000, target};
				pc_src    = pc_src_jump;
				rd_sel    = 2'd2;
				reg_write = 1'b1;
				pc_to_reg = 1'b1;
			end
			op_rtype: begin
				rd_sel = rd;
				case (func)
					fn_add: begin
						alu_op    = alu_add;
						reg_write = 1'b1;
					end
					fn_sub: begin
						alu_op    = alu_sub;
						reg_write = 1'b1;
					end
					fn_and: begin
						alu_op    = alu_and;
						reg_write = 1'b1;
					end
					fn_orr: begin
						alu_op    = alu_orr;
						reg_write = 1'b1;
					end
					fn_not: begin
						alu_op    = alu_not;
						reg_write = 1'b1;
					end
					fn_tcp: begin
						alu_op    = alu_tcp;
						reg_write = 1'b1;
					end
					fn_shl: begin
						alu_op    = alu_shl;
						reg_write = 1'b1;
					end
					fn_shr: begin
						alu_op    = alu_shr;
						reg_write = 1'b1;
					end
					fn_wwd: begin
						alu_op = alu_pass_a;
						is_wwd = 1'b1;
					end
					fn_jpr: begin
						alu_op = alu_pass_a;
						pc_src = pc_src_reg;
					end
					fn_jrl: begin
						alu_op    = alu_pass_a;
						pc_src    = pc_src_reg;
						rd_sel    = 2'd2;
						reg_write = 1'b1;
						pc_to_reg = 1'b1;
					end
					fn_hlt: is_halt = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [cpu_pkg::word_size-1:0] a,
	input  logic [cpu_pkg::word_size-1:0] b,
	input  cpu_pkg::alu_op_t              op,
	input  logic [3:0]                    opcode,
	output logic [cpu_pkg::word_size-1:0] result,
	output logic                          bcond
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_orr:    result = a | b;
			alu_not:    result = ~a;
			alu_tcp:    result = ~a + 1'b1;
			// single-bit shifts, right shift is logical
			alu_shl:    result = a << 1;
			alu_shr:    result = a >> 1;
			alu_pass_a: result = a;
			alu_pass_b: result = b;
			default:    result = '0;
		endcase
	end

	// branch test, signed view of a for bgz and blz
	always_comb begin
		case (opcode)
			op_bne:  bcond = (a != b);
			op_beq:  bcond = (a == b);
			op_bgz:  bcond = !a[word_size-1] && (a != '0);
			op_blz:  bcond = a[word_size-1];
			default: bcond = 1'b0;
		endcase
	end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	// word and register geometry fixed by the ISA
	localparam int word_size = 16;
	localparam int reg_count = 4;
	localparam int reg_addr_size = $clog2(reg_count);

	// opcodes, instruction bits 15:12
	localparam logic [3:0] op_bne = 4'd0;
	localparam logic [3:0] op_beq = 4'd1;
	localparam logic [3:0] op_bgz = 4'd2;
	localparam logic [3:0] op_blz = 4'd3;
	localparam logic [3:0] op_adi = 4'd4;
	localparam logic [3:0] op_ori = 4'd5;
	localparam logic [3:0] op_lhi = 4'd6;
	localparam logic [3:0] op_lwd = 4'd7;
	localparam logic [3:0] op_swd = 4'd8;
	localparam logic [3:0] op_jmp = 4'd9;
	localparam logic [3:0] op_jal = 4'd10;
	localparam logic [3:0] op_rtype = 4'd15;

	// function codes for op_rtype, instruction bits 5:0
	localparam logic [5:0] fn_add = 6'd0;
	localparam logic [5:0] fn_sub = 6'd1;
	localparam logic [5:0] fn_and = 6'd2;
	localparam logic [5:0] fn_orr = 6'd3;
	localparam logic [5:0] fn_not = 6'd4;
	localparam logic [5:0] fn_tcp = 6'd5;
	localparam logic [5:0] fn_shl = 6'd6;
	localparam logic [5:0] fn_shr = 6'd7;
	localparam logic [5:0] fn_jpr = 6'd25;
	localparam logic [5:0] fn_jrl = 6'd26;
	localparam logic [5:0] fn_wwd = 6'd28;
	localparam logic [5:0] fn_hlt = 6'd29;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_orr,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr,
		alu_pass_a,
		alu_pass_b
	} alu_op_t;

	// next-pc source
	typedef enum logic [1:0] {
		pc_src_next,
		pc_src_offset,
		pc_src_jump,
		pc_src_reg
	} pc_src_t;

endpackage
